//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := tb_game_control
FILELIST  := filelist.f
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-$(BIN) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- filelist.f
logic/game_pkg.sv
logic/uart_rx.sv
logic/debouncer.sv
logic/round_timer.sv
logic/command_decoder.sv
logic/command_queue.sv
logic/game_control.sv
verification/tb_game_control.sv

//--- logic/command_decoder.sv
module command_decoder (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic [7:0]                          rx_byte,
  input  logic                                rx_valid,
  input  logic [game_pkg::BUTTON_COUNT-1:0]   button_press,
  input  logic [game_pkg::SWITCH_COUNT-1:0]   switches,
  input  logic                                round_active,
  input  logic                                gravity_due,
  input  logic                                bar_due,
  output logic                                start_req,
  output game_pkg::command_t                  dec_cmd
);
  import game_pkg::*;

  logic [SWITCH_COUNT-1:0] sw_sync;
  logic [SWITCH_COUNT-1:0] sw_prev;
  logic [SWITCH_COUNT-1:0] sw_toggle;
  logic                    any_input;
  command_t                key_cmd;
  command_t                next_cmd;

  // Case-insensitive keyboard map.
  function automatic command_t map_key(input logic [7:0] key);
    logic [7:0] upper;
    upper = (key >= "a" && key <= "z") ? key - 8'd32 : key;
    case (upper)
      "A":      return LEFT;
      "D":      return RIGHT;
      "S":      return DOWN;
      "W", " ": return DROP;
      "C":      return HOLD;
      "X":      return ROTATE;
      "Z":      return ROTATE_REV;
      "B":      return BAR;
      default:  return NONE;
    endcase
  endfunction

  // Loaded from the pins in reset so a raised switch is no toggle.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      sw_sync <= switches;
      sw_prev <= switches;
    end else begin
      sw_sync <= switches;
      sw_prev <= sw_sync;
    end
  end

  assign sw_toggle = sw_sync ^ sw_prev;
  assign any_input = rx_valid || |button_press || |sw_toggle;
  assign key_cmd   = map_key(rx_byte);

  // Later assignments win.
  always_comb begin
    next_cmd = NONE;
    if (!round_active) begin
      if (any_input) next_cmd = START;
    end else begin
      if (gravity_due)     next_cmd = DOWN;
      if (bar_due)         next_cmd = BAR;
      if (button_press[0]) next_cmd = RIGHT;
      if (button_press[1]) next_cmd = DOWN;
      if (button_press[2]) next_cmd = ROTATE;
      if (button_press[3]) next_cmd = LEFT;
      if (sw_toggle[0])    next_cmd = DROP;
      if (sw_toggle[1])    next_cmd = HOLD;
      if (sw_toggle[2])    next_cmd = ROTATE_REV;
      if (sw_toggle[3])    next_cmd = BAR;
      if (rx_valid && key_cmd != NONE) next_cmd = key_cmd;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      dec_cmd   <= NONE;
      start_req <= 1'b0;
    end else begin
      dec_cmd   <= next_cmd;
      start_req <= next_cmd == START;
    end
  end

endmodule

//--- logic/command_queue.sv
module command_queue #(
  parameter int QUEUE_DEPTH = 16,
  parameter int CREDITS     = 4
) (
  input  logic               clk,
  input  logic               reset_n,
  input  game_pkg::command_t in_cmd,
  input  logic               cmd_credit,
  output game_pkg::command_t cmd,
  output logic               cmd_valid
);
  import game_pkg::*;

  localparam int AW  = $clog2(QUEUE_DEPTH);
  localparam int NW  = $clog2(QUEUE_DEPTH + 1);
  localparam int CRW = $clog2(CREDITS + 1);

  command_t       mem [QUEUE_DEPTH];
  logic [AW-1:0]  wr_ptr;
  logic [AW-1:0]  rd_ptr;
  logic [NW-1:0]  count;
  logic [CRW-1:0] credits;
  logic           push, empty, full, has_credit;
  logic           bypass, wr_en, rd_en, send;

  assign push       = in_cmd != NONE;
  assign empty      = count == '0;
  assign full       = count == NW'(QUEUE_DEPTH);
  assign has_credit = credits != '0;
  assign bypass     = empty && push && has_credit; // Skip the FIFO when nothing waits.
  assign rd_en      = !empty && has_credit;
  assign wr_en      = push && !full && !bypass;   // Full queue drops the push.
  assign send       = bypass || rd_en;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    return (ptr == AW'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= in_cmd;
    if (send)  cmd <= bypass ? in_cmd : mem[rd_ptr];
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      credits   <= CRW'(CREDITS);
      cmd_valid <= 1'b0;
    end else begin
      if (wr_en) wr_ptr <= next_ptr(wr_ptr);
      if (rd_en) rd_ptr <= next_ptr(rd_ptr);
      count     <= count + NW'(wr_en) - NW'(rd_en);
      cmd_valid <= send;
      case ({cmd_credit, send})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

//--- logic/debouncer.sv
module debouncer #(
  parameter int DEBOUNCE_CYCLES = 1_000_000
) (
  input  logic clk,
  input  logic reset_n,
  input  logic in,
  output logic press
);
  localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);

  logic [1:0]    in_sync;
  logic          stable;
  logic [CW-1:0] stable_cnt;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      in_sync    <= '0;
      stable     <= 1'b0;
      stable_cnt <= '0;
      press      <= 1'b0;
    end else begin
      in_sync <= {in_sync[0], in};
      press   <= 1'b0;
      if (in_sync[1] == stable) begin
        stable_cnt <= '0; // Bounce back, start over.
      end else if (stable_cnt == CW'(DEBOUNCE_CYCLES - 1)) begin
        stable     <= in_sync[1];
        stable_cnt <= '0;
        press      <= in_sync[1]; // Only the rising side counts.
      end else begin
        stable_cnt <= stable_cnt + 1'b1;
      end
    end
  end

endmodule

//--- logic/game_control.sv
module game_control #(
  parameter int CLOCK_DIVIDE    = 434,
  parameter int DEBOUNCE_CYCLES = 1_000_000,
  parameter int SEC_TICK        = 50_000_000,
  parameter int ROUND_SECONDS   = 60,
  parameter int GRAVITY_TICK    = 50_000_000,
  parameter int BAR_TICK        = 1_000_000_000,
  parameter int QUEUE_DEPTH     = 16,
  parameter int CREDITS         = 4
) (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic [31:0]                       rng,
  input  logic [game_pkg::BUTTON_COUNT-1:0] buttons,
  input  logic [game_pkg::SWITCH_COUNT-1:0] switches,
  input  logic                              uart_rx,
  input  logic                              game_end,
  input  logic                              cmd_credit,
  output game_pkg::command_t                cmd,
  output logic                              cmd_valid,
  output game_pkg::round_status_t           status,
  output logic [game_pkg::MASK_WIDTH-1:0]   hole_mask
);
  import game_pkg::*;

  logic [7:0]              rx_byte;
  logic                    rx_valid;
  logic [BUTTON_COUNT-1:0] button_press;
  logic                    gravity_due;
  logic                    bar_due;
  logic                    start_req;
  command_t                dec_cmd;

  uart_rx #(.CLOCK_DIVIDE(CLOCK_DIVIDE)) i_uart_rx (
    .clk(clk), .reset_n(reset_n), .rx(uart_rx), .rx_byte(rx_byte), .rx_valid(rx_valid)
  );

  for (genvar i = 0; i < BUTTON_COUNT; i++) begin : g_button
    debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_debouncer (
      .clk(clk), .reset_n(reset_n), .in(buttons[i]), .press(button_press[i])
    );
  end

  command_decoder i_command_decoder (
    .clk(clk), .reset_n(reset_n), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .button_press(button_press), .switches(switches), .round_active(status.active),
    .gravity_due(gravity_due), .bar_due(bar_due), .start_req(start_req), .dec_cmd(dec_cmd)
  );

  round_timer #(
    .SEC_TICK(SEC_TICK), .ROUND_SECONDS(ROUND_SECONDS),
    .GRAVITY_TICK(GRAVITY_TICK), .BAR_TICK(BAR_TICK)
  ) i_round_timer (
    .clk(clk), .reset_n(reset_n), .rng(rng), .start_req(start_req), .game_end(game_end),
    .dec_cmd(dec_cmd), .status(status), .gravity_due(gravity_due), .bar_due(bar_due),
    .hole_mask(hole_mask)
  );

  command_queue #(.QUEUE_DEPTH(QUEUE_DEPTH), .CREDITS(CREDITS)) i_command_queue (
    .clk(clk), .reset_n(reset_n), .in_cmd(dec_cmd), .cmd_credit(cmd_credit),
    .cmd(cmd), .cmd_valid(cmd_valid)
  );

endmodule

//--- logic/game_pkg.sv
package game_pkg;

  localparam int BUTTON_COUNT = 4;
  localparam int SWITCH_COUNT = 4;
  localparam int MASK_WIDTH   = 10; // Playfield columns.

  // Commands handed to the game engine.
  typedef enum logic [3:0] {
    NONE,
    START,
    LEFT,
    RIGHT,
    DOWN,
    DROP,
    ROTATE,
    ROTATE_REV,
    HOLD,
    BAR
  } command_t;

  // Round clock as seen by the engine and the display.
  typedef struct packed {
    logic       active;  // Round running.
    logic       over;    // One-cycle pulse at round end.
    logic [6:0] seconds; // Seconds left.
  } round_status_t;

endpackage

//--- logic/round_timer.sv
module round_timer #(
  parameter int SEC_TICK      = 50_000_000,
  parameter int ROUND_SECONDS = 60,
  parameter int GRAVITY_TICK  = 50_000_000,
  parameter int BAR_TICK      = 1_000_000_000
) (
  input  logic                               clk,
  input  logic                               reset_n,
  input  logic [31:0]                        rng,
  input  logic                               start_req,
  input  logic                               game_end,
  input  game_pkg::command_t                 dec_cmd,
  output game_pkg::round_status_t            status,
  output logic                               gravity_due,
  output logic                               bar_due,
  output logic [game_pkg::MASK_WIDTH-1:0]    hole_mask
);
  import game_pkg::*;

  localparam int SW = $clog2(SEC_TICK);
  localparam int GW = $clog2(GRAVITY_TICK) + 2;
  localparam int BW = $clog2(BAR_TICK) + 4; // Headroom while commands are held off.

  logic [SW-1:0] sec_cnt;
  logic [GW-1:0] grav_acc;
  logic [BW-1:0] bar_acc;
  logic          sec_tick;
  logic          round_end;

  assign sec_tick  = sec_cnt == SW'(SEC_TICK - 1);
  assign round_end = status.active && status.seconds == '0 && game_end;

  // Masked while the command is in flight so each crossing gives one command.
  assign gravity_due = grav_acc >= GW'(GRAVITY_TICK) && dec_cmd != DOWN;
  assign bar_due     = bar_acc >= BW'(BAR_TICK) && dec_cmd != BAR;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      status.active  <= 1'b0;
      status.over    <= 1'b0;
      status.seconds <= 7'(ROUND_SECONDS);
    end else begin
      status.over <= round_end;
      if (round_end) begin
        status.active <= 1'b0;
      end else if (start_req && !status.active) begin
        status.active  <= 1'b1;
        status.seconds <= 7'(ROUND_SECONDS);
      end else if (status.active && sec_tick && status.seconds != '0) begin
        status.seconds <= status.seconds - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n || !status.active) sec_cnt <= '0;
    else if (sec_tick)              sec_cnt <= '0;
    else                            sec_cnt <= sec_cnt + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!reset_n || !status.active) begin
      grav_acc <= '0;
    end else if (dec_cmd == DOWN) begin
      grav_acc <= (grav_acc >= GW'(GRAVITY_TICK)) ? grav_acc - GW'(GRAVITY_TICK) : '0;
    end else begin
      grav_acc <= grav_acc + 1'b1;
    end
  end

  // Random growth, zero to seven per cycle.
  always_ff @(posedge clk) begin
    if (!reset_n || !status.active) begin
      bar_acc <= '0;
    end else if (dec_cmd == BAR) begin
      bar_acc <= (bar_acc >= BW'(BAR_TICK)) ? bar_acc - BW'(BAR_TICK) : '0;
    end else begin
      bar_acc <= bar_acc + BW'(rng[22:20]);
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) hole_mask <= '0;
    else hole_mask <= (rng[19:16] < MASK_WIDTH) ? MASK_WIDTH'(1) << rng[19:16] : '0;
  end

endmodule

//--- logic/uart_rx.sv
module uart_rx #(
  parameter int CLOCK_DIVIDE = 434
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       rx,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);
  typedef enum logic [1:0] {IDLE, START_BIT, DATA_BITS, STOP_BIT} rx_state_t;

  localparam int CW = $clog2(CLOCK_DIVIDE);

  rx_state_t     state;
  logic [CW-1:0] div_cnt;
  logic [2:0]    bit_idx;
  logic [1:0]    rx_sync;
  logic          bit_end;

  assign bit_end = div_cnt == CW'(CLOCK_DIVIDE - 1); // Middle of a data or stop bit.

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rx_sync  <= 2'b11; // Line idles high.
      state    <= IDLE;
      div_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_sync  <= {rx_sync[0], rx};
      rx_valid <= 1'b0;
      case (state)
        IDLE: begin
          div_cnt <= '0;
          if (!rx_sync[1]) state <= START_BIT;
        end
        START_BIT: begin
          if (div_cnt == CW'(CLOCK_DIVIDE / 2 - 1)) begin
            div_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_sync[1] ? IDLE : DATA_BITS; // High again means a glitch.
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        DATA_BITS: begin
          if (bit_end) begin
            div_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= STOP_BIT;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        default: begin
          if (bit_end) begin
            state    <= IDLE;
            rx_valid <= rx_sync[1]; // Framing error drops the byte.
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB first.
  always_ff @(posedge clk) begin
    if (state == DATA_BITS && bit_end) rx_byte <= {rx_sync[1], rx_byte[7:1]};
  end

endmodule

//--- verification/tb_game_control.sv
module tb_game_control;
  timeunit 1ns;
  timeprecision 100ps;

  import game_pkg::*;

  localparam int CLOCK_DIVIDE    = 8;
  localparam int DEBOUNCE_CYCLES = 4;
  localparam int SEC_TICK        = 40;
  localparam int ROUND_SECONDS   = 5;
  localparam int GRAVITY_TICK    = 60;
  localparam int BAR_TICK        = 200;
  localparam int QUEUE_DEPTH     = 4;
  localparam int CREDITS         = 2;

  localparam logic [2:0] K_UART   = 0;
  localparam logic [2:0] K_BUTTON = 1;
  localparam logic [2:0] K_SHORT  = 2;
  localparam logic [2:0] K_SWITCH = 3;
  localparam logic [2:0] K_BURST  = 4;

  typedef struct packed {
    logic [2:0]         kind;
    logic [7:0]         arg;  // Byte or pin index.
    logic [2:0]         n;
    command_t [5:0]     exp;  // Element 0 comes first.
  } entry_t;

  logic                    clk;
  logic                    reset_n;
  logic [31:0]             rng;
  logic [BUTTON_COUNT-1:0] buttons;
  logic [SWITCH_COUNT-1:0] switches;
  logic                    uart_rx;
  logic                    game_end;
  logic                    cmd_credit;
  command_t                cmd;
  logic                    cmd_valid;
  round_status_t           status;
  logic [MASK_WIDTH-1:0]   hole_mask;

  command_t    got[$];
  int          got_time[$];
  int          cycle;
  int          owed;
  int          over_count;
  int          gap;
  logic        withhold;
  logic [2:0]  rng_field;
  logic [31:0] rng_prev;
  logic [31:0] rng_next;
  logic        mask_armed;
  entry_t      table_rows[$];

  game_control #(
    .CLOCK_DIVIDE(CLOCK_DIVIDE), .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
    .SEC_TICK(SEC_TICK), .ROUND_SECONDS(ROUND_SECONDS),
    .GRAVITY_TICK(GRAVITY_TICK), .BAR_TICK(BAR_TICK),
    .QUEUE_DEPTH(QUEUE_DEPTH), .CREDITS(CREDITS)
  ) i_game_control (
    .clk(clk), .reset_n(reset_n), .rng(rng), .buttons(buttons), .switches(switches),
    .uart_rx(uart_rx), .game_end(game_end), .cmd_credit(cmd_credit),
    .cmd(cmd), .cmd_valid(cmd_valid), .status(status), .hole_mask(hole_mask)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR %s: got %h, expected %h", name, actual, expected);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic fail(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  // One hot at the column, or empty when off the playfield.
  function automatic logic [MASK_WIDTH-1:0] mask_for(input logic [31:0] r);
    logic [MASK_WIDTH-1:0] m;
    m = '0;
    for (int c = 0; c < MASK_WIDTH; c++) if (r[19:16] == c) m[c] = 1'b1;
    return m;
  endfunction

  function automatic int count_of(input command_t c);
    int n;
    n = 0;
    foreach (got[i]) if (got[i] == c) n++;
    return n;
  endfunction

  // Sampled before the edge's updates land.
  always @(posedge clk) begin
    cycle++;
    if (cmd_valid) begin
      got.push_back(cmd);
      got_time.push_back(cycle);
      owed++;
      if (owed > CREDITS) fail("Engine received more commands than it has buffer space.");
    end
    if (status.over) over_count++;
    if (mask_armed) check("hole_mask", hole_mask, mask_for(rng_prev));
    rng_prev   = rng;
    mask_armed = reset_n;
  end

  // Engine model returns credits after a random gap.
  initial begin
    forever begin
      tick();
      cmd_credit = 1'b0;
      if (!withhold && owed > 0) begin
        if (gap == 0) begin
          cmd_credit = 1'b1;
          owed--;
          gap = $urandom_range(0, 3);
        end else begin
          gap--;
        end
      end
    end
  end

  initial begin
    forever begin
      tick();
      rng_next        = $urandom();
      rng_next[22:20] = rng_field;
      rng             = rng_next;
    end
  end

  task automatic uart_send(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      repeat (CLOCK_DIVIDE) tick();
    end
    tick();
  endtask

  task automatic wait_credits_back();
    int t;
    t = 0;
    while (owed != 0) begin
      tick();
      t++;
      if (t > 100) fail("Timeout waiting for the engine to return its credits.");
    end
  endtask

  // Credit test. Eight toggles in eight cycles against a held engine.
  task automatic burst();
    int t;
    t = 0;
    while (count_of(DOWN) == 0) begin
      tick();
      t++;
      if (t > 200) fail("Timeout waiting for a gravity step before the burst.");
    end
    wait_credits_back();
    got.delete();
    got_time.delete();
    withhold = 1'b1;
    for (int i = 0; i < 8; i++) begin
      switches[i % SWITCH_COUNT] = ~switches[i % SWITCH_COUNT];
      tick();
    end
    repeat (20) tick();
    check("delivered_while_held", got.size() - count_of(DOWN), CREDITS);
    withhold = 1'b0;
  endtask

  task automatic run_entry(input entry_t e);
    command_t want[$];
    command_t others[$];
    int       downs;
    int       near;
    int       done;
    int       t;
    downs = 0;
    near = 0;
    t = 0;
    for (int i = 0; i < e.n; i++) begin
      if (e.exp[i] == DOWN) downs++;
      else want.push_back(e.exp[i]);
    end
    repeat ($urandom_range(2, 10)) tick();
    got.delete();
    got_time.delete();
    case (e.kind)
      K_UART: uart_send(e.arg);
      K_BUTTON, K_SHORT: begin
        buttons[e.arg] = 1'b1;
        repeat ((e.kind == K_BUTTON) ? 10 : 2) tick();
        buttons[e.arg] = 1'b0;
      end
      K_SWITCH: switches[e.arg] = ~switches[e.arg];
      default: burst();
    endcase
    done = cycle;
    while (got.size() - count_of(DOWN) < want.size() || count_of(DOWN) < downs) begin
      tick();
      t++;
      if (t > 600) fail("Timeout waiting for the expected commands.");
    end
    repeat (30) tick();
    // A DOWN from the input lands right at the end of the stimulus.
    foreach (got[i]) begin
      if (got[i] != DOWN) others.push_back(got[i]);
      else if (got_time[i] >= done - 4 && got_time[i] <= done + 4) near++;
    end
    check("command_count", others.size(), want.size());
    foreach (want[i]) check("cmd", others[i], want[i]);
    if (downs > 0 && near == 0) fail("No DOWN command followed the DOWN input.");
    wait_credits_back();
  endtask

  function automatic entry_t row(input logic [2:0] kind, input logic [7:0] arg,
                                 input command_t c0 = NONE, input command_t c1 = NONE);
    entry_t e;
    e = '0;
    e.kind   = kind;
    e.arg    = arg;
    e.exp[0] = c0;
    e.exp[1] = c1;
    e.n      = (c0 == NONE) ? 3'd0 : (c1 == NONE) ? 3'd1 : 3'd2;
    return e;
  endfunction

  initial begin
    entry_t b;
    int     t;
    int     bars;
    int     over_before;
    logic [6:0] secs;
    void'($urandom(32'h88cf_8216));
    reset_n = 1'b0;
    rng = '0;
    buttons = '0;
    switches = '0;
    uart_rx = 1'b1;
    game_end = 1'b0;
    cmd_credit = 1'b0;
    withhold = 1'b0;
    rng_field = 3'd0;
    mask_armed = 1'b0;
    cycle = 0;
    owed = 0;
    over_count = 0;
    gap = 0;
    repeat (16) tick();
    reset_n = 1'b1;
    check("cmd_valid", cmd_valid, 0);
    check("status.active", status.active, 0);
    check("status.over", status.over, 0);
    check("hole_mask", hole_mask, 0);

    table_rows.push_back(row(K_UART, "a", START));
    table_rows.push_back(row(K_UART, "a", LEFT));
    table_rows.push_back(row(K_UART, "A", LEFT));
    table_rows.push_back(row(K_UART, "D", RIGHT));
    table_rows.push_back(row(K_UART, "d", RIGHT));
    table_rows.push_back(row(K_UART, "s", DOWN));
    table_rows.push_back(row(K_UART, "W", DROP));
    table_rows.push_back(row(K_UART, "w", DROP));
    table_rows.push_back(row(K_UART, " ", DROP));
    table_rows.push_back(row(K_UART, "c", HOLD));
    table_rows.push_back(row(K_UART, "C", HOLD));
    table_rows.push_back(row(K_UART, "X", ROTATE));
    table_rows.push_back(row(K_UART, "x", ROTATE));
    table_rows.push_back(row(K_UART, "z", ROTATE_REV));
    table_rows.push_back(row(K_UART, "Z", ROTATE_REV));
    table_rows.push_back(row(K_UART, "B", BAR));
    table_rows.push_back(row(K_UART, "b", BAR));
    table_rows.push_back(row(K_UART, "q"));
    table_rows.push_back(row(K_UART, "1"));
    table_rows.push_back(row(K_BUTTON, 0, RIGHT));
    table_rows.push_back(row(K_BUTTON, 1, DOWN));
    table_rows.push_back(row(K_BUTTON, 2, ROTATE));
    table_rows.push_back(row(K_BUTTON, 3, LEFT));
    table_rows.push_back(row(K_SHORT, 2));
    table_rows.push_back(row(K_SWITCH, 0, DROP));
    table_rows.push_back(row(K_SWITCH, 0, DROP));
    table_rows.push_back(row(K_SWITCH, 1, HOLD));
    table_rows.push_back(row(K_SWITCH, 2, ROTATE_REV));
    table_rows.push_back(row(K_SWITCH, 3, BAR));
    // Two delivered on credit, four queued, two dropped.
    b = row(K_BURST, 0, DROP, HOLD);
    b.exp[2] = ROTATE_REV;
    b.exp[3] = BAR;
    b.exp[4] = DROP;
    b.exp[5] = HOLD;
    b.n = 3'd6;
    table_rows.push_back(b);

    foreach (table_rows[i]) begin
      run_entry(table_rows[i]);
      check("status.active", status.active, 1);
    end

    // Gravity alone.
    got.delete();
    got_time.delete();
    repeat (500) tick();
    check("bar_count", count_of(BAR), 0);
    if (count_of(DOWN) < 6) fail("Too few gravity steps in the window.");
    for (int i = 1; i < got.size(); i++) begin
      if (got_time[i] - got_time[i-1] < GRAVITY_TICK) fail("Gravity steps came too close.");
    end

    rng_field = 3'd7;
    got.delete();
    repeat (300) tick();
    bars = count_of(BAR);
    if (bars < 5) fail("Too few garbage rows in the window.");
    rng_field = 3'd0;

    // Seconds are long gone, so the round ends at once.
    over_before = over_count;
    game_end = 1'b1;
    t = 0;
    while (status.active) begin
      tick();
      t++;
      if (t > 50) fail("Timeout waiting for the round to end.");
    end
    repeat (10) tick();
    check("over_count", over_count, over_before + 1);

    wait_credits_back();
    got.delete();
    over_before = over_count;
    uart_send("d");
    t = 0;
    while (!status.active) begin
      tick();
      t++;
      if (t > 50) fail("Timeout waiting for a new round to start.");
    end
    check("status.seconds", status.seconds, ROUND_SECONDS);
    secs = status.seconds;
    t = 0;
    while (status.active) begin
      tick();
      t++;
      if (status.seconds != secs) begin
        check("status.seconds", status.seconds, secs - 1);
        secs = status.seconds;
      end
      if (t > 400) fail("Timeout waiting for the countdown to finish.");
    end
    check("status.seconds", status.seconds, 0);
    repeat (10) tick();
    check("over_count", over_count, over_before + 1);
    check("first_cmd", got[0], START);

    $display("TB PASSED");
    $finish;
  end

endmodule
